// ==== rtl/p4_router_config.svh ====
/* Echo router build parameters */

`ifndef P4_ROUTER_CONFIG_SVH
`define P4_ROUTER_CONFIG_SVH

// Port groups, 8-bit ports are numbered first
`define P4R_NUM_8B_PORTS  2
`define P4R_NUM_32B_PORTS 2
`define P4R_NUM_PORTS     (`P4R_NUM_8B_PORTS + `P4R_NUM_32B_PORTS)

// Beats held per port buffer
`define P4R_FIFO_DEPTH    4
`define P4R_CNT_WIDTH     16

`endif

// ==== rtl/p4_router_pkg.sv ====
/* Echo router types */

`default_nettype none

`include "p4_router_config.svh"

package p4_router_pkg;

    // One full beat of an 8-bit port
    typedef struct packed {
        logic [7:0]  data;
        logic        last;
    } beat_8b_t;

    // One full beat of a 32-bit port
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } beat_32b_t;

    typedef logic [`P4R_CNT_WIDTH-1:0] pkt_cnt_t;

endpackage

`default_nettype wire

// ==== rtl/axis_phys_if.sv ====
/* Physical port stream */

`timescale 1ns/1ps
`default_nettype none

interface axis_phys_if #(
    parameter int DATA_BYTES = 1
);

    logic [DATA_BYTES*8-1:0] tdata;
    logic                    tlast;
    logic                    tvalid;
    logic                    tready;

    // Transfer on tvalid and tready both high
    modport source (
        output tdata, tlast, tvalid,
        input  tready
    );

    modport sink (
        input  tdata, tlast, tvalid,
        output tready
    );

endinterface

`default_nettype wire

// ==== rtl/echo_fifo.sv ====
/* Beat FIFO */

`timescale 1ns/1ps
`default_nettype none

module echo_fifo #(
    parameter type beat_t = logic [8:0],
    parameter int  DEPTH  = 4
) (
    input  logic  phys_port_clk_ifc,
    input  logic  rst_n,
    input  logic  wr_en,
    input  beat_t wr_beat,
    input  logic  rd_en,
    output logic  full,
    output logic  empty,
    output beat_t rd_beat
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    beat_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A pop frees the slot for a write in the same cycle
    assign rd_ok   = rd_en && !empty;
    assign wr_ok   = wr_en && (!full || rd_ok);
    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign rd_beat = mem[rd_ptr];

    always_ff @(posedge phys_port_clk_ifc) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) wr_ptr <= ptr_next(wr_ptr);
            if (rd_ok) rd_ptr <= ptr_next(rd_ptr);
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////// Checks

    a_no_overflow: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        wr_en && full |-> rd_en) else $error("write to full FIFO");

    a_no_underflow: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        rd_en |-> !empty) else $error("read from empty FIFO");

endmodule

`default_nettype wire

// ==== rtl/port_stats.sv ====
/* Port packet counters */

`timescale 1ns/1ps
`default_nettype none

module port_stats
    import p4_router_pkg::*;
(
    input  logic     phys_port_clk_ifc,
    input  logic     rst_n,
    input  logic     ing_pkt_done,
    input  logic     drop_pkt_done,
    input  logic     egr_pkt_done,
    input  logic     cnt_clear,
    output pkt_cnt_t ing_pkt_cnt,
    output pkt_cnt_t egr_pkt_cnt,
    output pkt_cnt_t drop_pkt_cnt
);

    // Clear wins over a count in the same cycle
    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            ing_pkt_cnt  <= '0;
            egr_pkt_cnt  <= '0;
            drop_pkt_cnt <= '0;
        end else if (cnt_clear) begin
            ing_pkt_cnt  <= '0;
            egr_pkt_cnt  <= '0;
            drop_pkt_cnt <= '0;
        end else begin
            if (ing_pkt_done) begin
                ing_pkt_cnt <= ing_pkt_cnt + 1'b1;
            end
            if (egr_pkt_done) begin
                egr_pkt_cnt <= egr_pkt_cnt + 1'b1;
            end
            if (drop_pkt_done) begin
                drop_pkt_cnt <= drop_pkt_cnt + 1'b1;
            end
        end
    end

    // A packet is either kept or dropped, never both
    a_keep_or_drop: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        !(ing_pkt_done && drop_pkt_done)) else $error("packet both kept and dropped");

endmodule

`default_nettype wire

// ==== rtl/phys_port_echo.sv ====
/* Single port echo path */

`timescale 1ns/1ps
`default_nettype none

`include "p4_router_config.svh"

module phys_port_echo
    import p4_router_pkg::*;
#(
    parameter type beat_t     = beat_8b_t,
    parameter int  DATA_BYTES = 1
) (
    input  logic     phys_port_clk_ifc,
    input  logic     rst_n,
    input  logic     port_enable,
    input  logic     cnt_clear,
    axis_phys_if.sink   ing,
    axis_phys_if.source egr,
    output pkt_cnt_t ing_pkt_cnt,
    output pkt_cnt_t egr_pkt_cnt,
    output pkt_cnt_t drop_pkt_cnt
);

    logic  in_pkt;
    logic  keep_q;
    logic  keep_cur;
    logic  ing_hs;
    logic  wr_en;
    logic  rd_en;
    logic  full;
    logic  empty;
    beat_t wr_beat;
    beat_t rd_beat;

    if ($bits(beat_t) != DATA_BYTES * 8 + 1) begin : g_width_check
        $error("beat_t width does not match DATA_BYTES");
    end

    ////////////////////////////// Enable gate

    // Decision taken on the first beat, held until tlast
    assign keep_cur  = in_pkt ? keep_q : port_enable;
    assign ing.tready = keep_cur ? !full : 1'b1;
    assign ing_hs    = ing.tvalid && ing.tready;
    assign wr_en     = ing_hs && keep_cur;

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
            keep_q <= 1'b0;
        end else if (ing_hs) begin
            in_pkt <= !ing.tlast;
            keep_q <= keep_cur;
        end
    end

    assign wr_beat.data = ing.tdata;
    assign wr_beat.last = ing.tlast;

    ////////////////////////////// Buffer and egress

    echo_fifo #(
        .beat_t (beat_t),
        .DEPTH  (`P4R_FIFO_DEPTH)
    ) fifo_inst (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .wr_en             (wr_en),
        .wr_beat           (wr_beat),
        .rd_en             (rd_en),
        .full              (full),
        .empty             (empty),
        .rd_beat           (rd_beat)
    );

    assign egr.tvalid = !empty;
    assign egr.tdata  = rd_beat.data;
    assign egr.tlast  = rd_beat.last;
    assign rd_en      = egr.tvalid && egr.tready;

    port_stats stats_inst (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .ing_pkt_done      (wr_en && ing.tlast),
        .drop_pkt_done     (ing_hs && !keep_cur && ing.tlast),
        .egr_pkt_done      (rd_en && rd_beat.last),
        .cnt_clear         (cnt_clear),
        .ing_pkt_cnt       (ing_pkt_cnt),
        .egr_pkt_cnt       (egr_pkt_cnt),
        .drop_pkt_cnt      (drop_pkt_cnt)
    );

endmodule

`default_nettype wire

// ==== rtl/p4_router_echo.sv ====
/* Physical port echo router */

`timescale 1ns/1ps
`default_nettype none

`include "p4_router_config.svh"

module p4_router_echo
    import p4_router_pkg::*;
(
    input  logic                          phys_port_clk_ifc,
    input  logic                          rst_n,

    input  logic [7:0]                    ing_8b_tdata  [`P4R_NUM_8B_PORTS],
    input  logic [`P4R_NUM_8B_PORTS-1:0]  ing_8b_tlast,
    input  logic [`P4R_NUM_8B_PORTS-1:0]  ing_8b_tvalid,
    output logic [`P4R_NUM_8B_PORTS-1:0]  ing_8b_tready,
    output logic [7:0]                    egr_8b_tdata  [`P4R_NUM_8B_PORTS],
    output logic [`P4R_NUM_8B_PORTS-1:0]  egr_8b_tlast,
    output logic [`P4R_NUM_8B_PORTS-1:0]  egr_8b_tvalid,
    input  logic [`P4R_NUM_8B_PORTS-1:0]  egr_8b_tready,

    input  logic [31:0]                   ing_32b_tdata [`P4R_NUM_32B_PORTS],
    input  logic [`P4R_NUM_32B_PORTS-1:0] ing_32b_tlast,
    input  logic [`P4R_NUM_32B_PORTS-1:0] ing_32b_tvalid,
    output logic [`P4R_NUM_32B_PORTS-1:0] ing_32b_tready,
    output logic [31:0]                   egr_32b_tdata [`P4R_NUM_32B_PORTS],
    output logic [`P4R_NUM_32B_PORTS-1:0] egr_32b_tlast,
    output logic [`P4R_NUM_32B_PORTS-1:0] egr_32b_tvalid,
    input  logic [`P4R_NUM_32B_PORTS-1:0] egr_32b_tready,

    input  logic [`P4R_NUM_PORTS-1:0]     port_enable,
    input  logic [`P4R_NUM_PORTS-1:0]     cnt_clear,
    output pkt_cnt_t                      ing_pkt_cnt  [`P4R_NUM_PORTS],
    output pkt_cnt_t                      egr_pkt_cnt  [`P4R_NUM_PORTS],
    output pkt_cnt_t                      drop_pkt_cnt [`P4R_NUM_PORTS]
);

    localparam int BYTES_8B  = 1;
    localparam int BYTES_32B = 4;

    ////////////////////////////// 8-bit ports

    for (genvar i = 0; i < `P4R_NUM_8B_PORTS; i++) begin : g_8b
        axis_phys_if #(.DATA_BYTES(BYTES_8B)) ing_if ();
        axis_phys_if #(.DATA_BYTES(BYTES_8B)) egr_if ();

        assign ing_if.tdata     = ing_8b_tdata[i];
        assign ing_if.tlast     = ing_8b_tlast[i];
        assign ing_if.tvalid    = ing_8b_tvalid[i];
        assign ing_8b_tready[i] = ing_if.tready;
        assign egr_8b_tdata[i]  = egr_if.tdata;
        assign egr_8b_tlast[i]  = egr_if.tlast;
        assign egr_8b_tvalid[i] = egr_if.tvalid;
        assign egr_if.tready    = egr_8b_tready[i];

        phys_port_echo #(
            .beat_t     (beat_8b_t),
            .DATA_BYTES (BYTES_8B)
        ) echo_inst (
            .phys_port_clk_ifc (phys_port_clk_ifc),
            .rst_n             (rst_n),
            .port_enable       (port_enable[i]),
            .cnt_clear         (cnt_clear[i]),
            .ing               (ing_if),
            .egr               (egr_if),
            .ing_pkt_cnt       (ing_pkt_cnt[i]),
            .egr_pkt_cnt       (egr_pkt_cnt[i]),
            .drop_pkt_cnt      (drop_pkt_cnt[i])
        );
    end

    ////////////////////////////// 32-bit ports

    // Numbered after all 8-bit ports
    for (genvar i = 0; i < `P4R_NUM_32B_PORTS; i++) begin : g_32b
        localparam int P = `P4R_NUM_8B_PORTS + i;

        axis_phys_if #(.DATA_BYTES(BYTES_32B)) ing_if ();
        axis_phys_if #(.DATA_BYTES(BYTES_32B)) egr_if ();

        assign ing_if.tdata      = ing_32b_tdata[i];
        assign ing_if.tlast      = ing_32b_tlast[i];
        assign ing_if.tvalid     = ing_32b_tvalid[i];
        assign ing_32b_tready[i] = ing_if.tready;
        assign egr_32b_tdata[i]  = egr_if.tdata;
        assign egr_32b_tlast[i]  = egr_if.tlast;
        assign egr_32b_tvalid[i] = egr_if.tvalid;
        assign egr_if.tready     = egr_32b_tready[i];

        phys_port_echo #(
            .beat_t     (beat_32b_t),
            .DATA_BYTES (BYTES_32B)
        ) echo_inst (
            .phys_port_clk_ifc (phys_port_clk_ifc),
            .rst_n             (rst_n),
            .port_enable       (port_enable[P]),
            .cnt_clear         (cnt_clear[P]),
            .ing               (ing_if),
            .egr               (egr_if),
            .ing_pkt_cnt       (ing_pkt_cnt[P]),
            .egr_pkt_cnt       (egr_pkt_cnt[P]),
            .drop_pkt_cnt      (drop_pkt_cnt[P])
        );
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
/* Testbench clock and reset */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic phys_port_clk_ifc,
    output logic rst_n
);

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #(PERIOD_NS / 2) phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge phys_port_clk_ifc);
        @(negedge phys_port_clk_ifc);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/p4_router_echo_tb.sv ====
/* Echo router testbench */

`timescale 1ns/1ps
`default_nettype none

`include "p4_router_config.svh"

module p4_router_echo_tb
    import p4_router_pkg::*;
();

    localparam int N8         = `P4R_NUM_8B_PORTS;
    localparam int N32        = `P4R_NUM_32B_PORTS;
    localparam int NP         = `P4R_NUM_PORTS;
    localparam int BP_PORT    = N8;
    localparam int DROP_PORT  = 1;
    localparam int GATE_PORT  = NP - 1;
    // Whole run takes a few hundred cycles
    localparam int MAX_CYCLES = 4000;

    logic          phys_port_clk_ifc;
    logic          rst_n;
    wire  [7:0]    ing_8b_tdata  [N8];
    wire  [N8-1:0] ing_8b_tlast;
    wire  [N8-1:0] ing_8b_tvalid;
    wire  [N8-1:0] ing_8b_tready;
    wire  [7:0]    egr_8b_tdata  [N8];
    wire  [N8-1:0] egr_8b_tlast;
    wire  [N8-1:0] egr_8b_tvalid;
    wire  [N8-1:0] egr_8b_tready;
    wire  [31:0]    ing_32b_tdata [N32];
    wire  [N32-1:0] ing_32b_tlast;
    wire  [N32-1:0] ing_32b_tvalid;
    wire  [N32-1:0] ing_32b_tready;
    wire  [31:0]    egr_32b_tdata [N32];
    wire  [N32-1:0] egr_32b_tlast;
    wire  [N32-1:0] egr_32b_tvalid;
    wire  [N32-1:0] egr_32b_tready;
    logic [NP-1:0] port_enable;
    logic [NP-1:0] cnt_clear;
    pkt_cnt_t      ing_pkt_cnt  [NP];
    pkt_cnt_t      egr_pkt_cnt  [NP];
    pkt_cnt_t      drop_pkt_cnt [NP];

    // Per-port view over both port groups
    logic [31:0] in_data   [NP] = '{default: '0};
    logic        in_last   [NP] = '{default: 1'b0};
    logic        in_valid  [NP] = '{default: 1'b0};
    logic        out_ready [NP];
    wire         in_ready  [NP];
    wire  [31:0] out_data  [NP];
    wire         out_last  [NP];
    wire         out_valid [NP];

    // Queued beats as {keep, last, data}
    logic [33:0] tx_q  [NP][$];
    // Expected beats as {last, data}
    logic [32:0] exp_q [NP][$];
    int          kept    [NP] = '{default: 0};
    int          dropped [NP] = '{default: 0};
    int          value_errs = 0;
    int          other_errs = 0;
    string       cur_test = "reset";
    logic [15:0] lfsr = 16'd99;

    tb_clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (5)
    ) clock_gen_inst (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n)
    );

    p4_router_echo p4_router_echo_inst (.*);

    for (genvar i = 0; i < NP; i++) begin : g_pins
        if (i < N8) begin : g_8b
            assign ing_8b_tdata[i]  = in_data[i][7:0];
            assign ing_8b_tlast[i]  = in_last[i];
            assign ing_8b_tvalid[i] = in_valid[i];
            assign egr_8b_tready[i] = out_ready[i];
            assign in_ready[i]      = ing_8b_tready[i];
            assign out_data[i]      = {24'h0, egr_8b_tdata[i]};
            assign out_last[i]      = egr_8b_tlast[i];
            assign out_valid[i]     = egr_8b_tvalid[i];
        end else begin : g_32b
            assign ing_32b_tdata[i-N8]  = in_data[i];
            assign ing_32b_tlast[i-N8]  = in_last[i];
            assign ing_32b_tvalid[i-N8] = in_valid[i];
            assign egr_32b_tready[i-N8] = out_ready[i];
            assign in_ready[i]          = ing_32b_tready[i-N8];
            assign out_data[i]          = egr_32b_tdata[i-N8];
            assign out_last[i]          = egr_32b_tlast[i-N8];
            assign out_valid[i]         = egr_32b_tvalid[i-N8];
        end
    end

    ////////////////////////////// Driver and monitor

    always @(posedge phys_port_clk_ifc) begin
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (in_valid[p] && in_ready[p]) begin
                    if (tx_q[p][0][33]) begin
                        exp_q[p].push_back(tx_q[p][0][32:0]);
                    end
                    void'(tx_q[p].pop_front());
                end
                if (out_valid[p] && exp_q[p].size() == 0) begin
                    other_errs++;
                    $display("%s: port %0d shows an egress beat that was never sent", cur_test, p);
                end else if (out_valid[p] && out_ready[p]) begin
                    if ({out_last[p], out_data[p]} != exp_q[p][0]) begin
                        value_errs++;
                        $display("Error %s: port %0d beat expected %h, actual %h",
                                 cur_test, p, exp_q[p][0], {out_last[p], out_data[p]});
                    end
                    void'(exp_q[p].pop_front());
                end
                in_valid[p] <= (tx_q[p].size() != 0);
                if (tx_q[p].size() != 0) begin
                    in_data[p] <= tx_q[p][0][31:0];
                    in_last[p] <= tx_q[p][0][32];
                end
            end
        end
    end

    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge phys_port_clk_ifc);
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////// Helpers

    // 16-bit Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[15]};
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
        return r;
    endfunction

    task automatic send_packet(input int p, input int len, input logic keep);
        for (int i = 0; i < len; i++) begin
            tx_q[p].push_back({keep, i == len - 1, rand_bits(p < N8 ? 8 : 32)});
        end
        if (keep) begin
            kept[p]++;
        end else begin
            dropped[p]++;
        end
    endtask

    task automatic wait_tx(input int p, input int left);
        while (tx_q[p].size() > left) begin
            @(posedge phys_port_clk_ifc);
        end
    endtask

    task automatic wait_idle();
        int busy;
        do begin
            @(posedge phys_port_clk_ifc);
            busy = 0;
            for (int p = 0; p < NP; p++) begin
                busy += tx_q[p].size() + exp_q[p].size();
            end
        end while (busy != 0);
        repeat (2) @(posedge phys_port_clk_ifc);
    endtask

    task automatic check_value(input string what, input int port, input int expected,
                               input int actual);
        if (actual != expected) begin
            value_errs++;
            $display("Error %s: %s on port %0d expected %0d, actual %0d",
                     cur_test, what, port, expected, actual);
        end
    endtask

    task automatic check_counters();
        for (int p = 0; p < NP; p++) begin
            check_value("ing_pkt_cnt", p, kept[p], ing_pkt_cnt[p]);
            check_value("egr_pkt_cnt", p, kept[p], egr_pkt_cnt[p]);
            check_value("drop_pkt_cnt", p, dropped[p], drop_pkt_cnt[p]);
        end
    endtask

    ////////////////////////////// Tests

    task automatic echo_test();
        cur_test = "echo";
        for (int p = 0; p < NP; p++) begin
            if (!in_ready[p] || out_valid[p]) begin
                other_errs++;
                $display("echo: port %0d is not idle after reset", p);
            end
            send_packet(p, rand_bits(4) % 12 + 1, 1'b1);
        end
        wait_idle();
    endtask

    task automatic backpressure_test();
        cur_test = "backpressure";
        out_ready[BP_PORT] <= 1'b0;
        send_packet(BP_PORT, 10, 1'b1);
        do begin
            @(posedge phys_port_clk_ifc);
        end while (in_ready[BP_PORT]);
        check_value("beats before stall", BP_PORT, `P4R_FIFO_DEPTH, 10 - tx_q[BP_PORT].size());
        repeat (3) @(posedge phys_port_clk_ifc);
        out_ready[BP_PORT] <= 1'b1;
        wait_idle();
    endtask

    task automatic drop_test();
        int ing0;
        int egr0;
        cur_test = "drop";
        ing0 = ing_pkt_cnt[DROP_PORT];
        egr0 = egr_pkt_cnt[DROP_PORT];
        port_enable[DROP_PORT] <= 1'b0;
        repeat (3) send_packet(DROP_PORT, rand_bits(4) % 12 + 1, 1'b0);
        wait_idle();
        port_enable[DROP_PORT] <= 1'b1;
        check_value("drop_pkt_cnt", DROP_PORT, 3, drop_pkt_cnt[DROP_PORT]);
        check_value("ing_pkt_cnt", DROP_PORT, ing0, ing_pkt_cnt[DROP_PORT]);
        check_value("egr_pkt_cnt", DROP_PORT, egr0, egr_pkt_cnt[DROP_PORT]);
    endtask

    task automatic gate_test();
        cur_test = "enable_gate";
        port_enable[GATE_PORT] <= 1'b0;
        send_packet(GATE_PORT, 4, 1'b0);
        send_packet(GATE_PORT, 3, 1'b1);
        // Enable rises after the first beat of the dropped packet
        wait_tx(GATE_PORT, 6);
        port_enable[GATE_PORT] <= 1'b1;
        wait_idle();
        send_packet(GATE_PORT, 5, 1'b1);
        wait_tx(GATE_PORT, 4);
        port_enable[GATE_PORT] <= 1'b0;
        wait_idle();
        port_enable[GATE_PORT] <= 1'b1;
    endtask

    task automatic counter_test();
        cur_test = "counters";
        wait_idle();
        check_counters();
        // Port with kept and dropped packets, so all three counters are nonzero
        cnt_clear[DROP_PORT] <= 1'b1;
        @(posedge phys_port_clk_ifc);
        cnt_clear[DROP_PORT] <= 1'b0;
        @(posedge phys_port_clk_ifc);
        kept[DROP_PORT] = 0;
        dropped[DROP_PORT] = 0;
        check_counters();
    endtask

    initial begin
        for (int p = 0; p < NP; p++) begin
            out_ready[p] <= 1'b1;
        end
        port_enable <= '1;
        cnt_clear   <= '0;
        @(posedge rst_n);
        @(posedge phys_port_clk_ifc);
        echo_test();
        backpressure_test();
        drop_test();
        gate_test();
        counter_test();
        $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
rtl/p4_router_pkg.sv
rtl/axis_phys_if.sv
rtl/echo_fifo.sv
rtl/port_stats.sv
rtl/phys_port_echo.sv
rtl/p4_router_echo.sv
tb/tb_clock_gen.sv
tb/p4_router_echo_tb.sv

// ==== Makefile ====
# Verilator build and run of the echo router testbench

VERILATOR ?= verilator
TOP       ?= p4_router_echo_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
